/* hdl/fft_consts.svh */
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

////////////////////////////////////////////////////////////
// transform sizes
////////////////////////////////////////////////////////////

`define FFT_N       8
`define FFT_LEAF_N  4

////////////////////////////////////////////////////////////
// data and index widths
////////////////////////////////////////////////////////////

`define FFT_W       16
`define FFT_ADDR_W  3

// twiddle format Q1.14, cos(pi/4) rounded
`define FFT_TW_FRAC 14
`define FFT_TW_C45  11585

`endif

/* hdl/fft_data_pkg.sv */
`include "fft_consts.svh"

package fft_data_pkg;

    // one complex sample, real part in the upper half
    typedef struct packed {
        logic signed [`FFT_W-1:0] re;
        logic signed [`FFT_W-1:0] im;
    } sample_t;

    // bin index inside one 4-point leaf
    typedef logic [$clog2(`FFT_LEAF_N)-1:0] bin_idx_t;

    // butterfly result pair, lo goes to bin addr and hi to bin addr+4
    typedef struct packed {
        logic     en;
        bin_idx_t addr;
        sample_t  lo;
        sample_t  hi;
    } bfly_write_t;

endpackage

/* hdl/fft_ctrl_pkg.sv */
package fft_ctrl_pkg;

    // frame level states of the core
    typedef enum logic [1:0] {
        st_collect = 2'd0,
        st_combine = 2'd1,
        st_unload  = 2'd2
    } core_state_t;

    // butterfly unit read sequencer
    typedef enum logic {
        cs_idle = 1'b0,
        cs_run  = 1'b1
    } comb_state_t;

endpackage

/* hdl/fft4_leaf.sv */
`include "fft_consts.svh"

module fft4_leaf
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid_i,
    input  fft_data_pkg::sample_t  in_sample_i,
    input  logic                   rd_i,
    output logic                   full_o,
    output fft_data_pkg::sample_t  bin_o
);
    import fft_data_pkg::*;

    sample_t                     acc [`FFT_LEAF_N];
    logic [$clog2(`FFT_LEAF_N):0] cnt;
    bin_idx_t                    rd_ptr;

    // multiply by W4^e, W4 = -j
    function automatic sample_t rotate(sample_t s, bin_idx_t e);
        sample_t r;
        case (e)
            2'd0:
            begin
                r = s;
            end
            2'd1:
            begin
                r.re = s.im;
                r.im = -s.re;
            end
            2'd2:
            begin
                r.re = -s.re;
                r.im = -s.im;
            end
            default:
            begin
                r.re = -s.im;
                r.im = s.re;
            end
        endcase
        return r;
    endfunction

    function automatic sample_t add_s(sample_t a, sample_t b);
        sample_t r;
        r.re = a.re + b.re;
        r.im = a.im + b.im;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // on-the-fly DFT, sample n adds W4^(n*k) x into bin k
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (in_valid_i)
        begin
            for (int k = 0; k < `FFT_LEAF_N; k++)
            begin
                // first sample of the frame overwrites old contents
                acc[k] <= add_s((cnt == '0) ? sample_t'('0) : acc[k],
                                rotate(in_sample_i, bin_idx_t'(int'(cnt) * k)));
            end
        end
    end

    // sample count and read pointer
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt    <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (in_valid_i)
            begin
                cnt <= cnt + 1'b1;
            end
            if (rd_i)
            begin
                rd_ptr <= rd_ptr + 1'b1;
                // last bin read frees the leaf
                if (rd_ptr == bin_idx_t'(`FFT_LEAF_N - 1))
                begin
                    cnt <= '0;
                end
            end
        end
    end

    assign full_o = (cnt == `FFT_LEAF_N);
    assign bin_o  = acc[rd_ptr];

    // core steering must never push into a leaf still holding a frame
    a_no_write_when_full : assert property (
        @(posedge clk) disable iff (reset) full_o |-> !in_valid_i
    );

endmodule

/* hdl/twiddle_combine.sv */
`include "fft_consts.svh"

module twiddle_combine
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_i,
    input  fft_data_pkg::sample_t      even_i,
    input  fft_data_pkg::sample_t      odd_i,
    output logic                       rd_o,
    output fft_data_pkg::bfly_write_t  wr_o,
    output logic                       done_o
);
    import fft_data_pkg::*;
    import fft_ctrl_pkg::*;

    localparam logic signed [31:0] C45  = `FFT_TW_C45;
    localparam logic signed [31:0] BIAS = 32'sd1 <<< (`FFT_TW_FRAC - 1);

    comb_state_t        state;
    bin_idx_t           k_q;
    logic signed [31:0] pa;
    logic signed [31:0] pb;
    sample_t            t_c;

    // stage 1 and stage 2 registers
    logic     s1_valid;
    bin_idx_t s1_k;
    sample_t  s1_even;
    sample_t  s1_t;
    logic     wr_en_q;
    logic     done_q;
    bin_idx_t wr_addr_q;
    sample_t  wr_lo_q;
    sample_t  wr_hi_q;

    // round to nearest and drop back to sample width
    function automatic logic signed [`FFT_W-1:0] rnd(logic signed [31:0] v);
        logic signed [31:0] s;
        s = (v + BIAS) >>> `FFT_TW_FRAC;
        return s[`FFT_W-1:0];
    endfunction

    // read sequencer, one leaf bin per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= cs_idle;
            k_q   <= '0;
        end
        else if (state == cs_idle)
        begin
            if (start_i)
            begin
                state <= cs_run;
                k_q   <= '0;
            end
        end
        else
        begin
            k_q <= k_q + 1'b1;
            if (k_q == bin_idx_t'(`FFT_LEAF_N - 1))
            begin
                state <= cs_idle;
            end
        end
    end

    assign rd_o = (state == cs_run);

    ////////////////////////////////////////////////////////////
    // stage 1: T = W8^k * O[k]
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        pa = C45 * 32'(odd_i.re);
        pb = C45 * 32'(odd_i.im);
        case (k_q)
            2'd0:
            begin
                t_c = odd_i;
            end
            2'd1:
            begin
                t_c.re = rnd(pa + pb);
                t_c.im = rnd(pb - pa);
            end
            2'd2:
            begin
                // -j is exact
                t_c.re = odd_i.im;
                t_c.im = -odd_i.re;
            end
            default:
            begin
                t_c.re = rnd(pb - pa);
                t_c.im = rnd(-pa - pb);
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1_valid <= 1'b0;
            wr_en_q  <= 1'b0;
            done_q   <= 1'b0;
        end
        else
        begin
            s1_valid <= rd_o;
            wr_en_q  <= s1_valid;
            done_q   <= s1_valid && (s1_k == bin_idx_t'(`FFT_LEAF_N - 1));
        end
    end

    // bin index rides along with its data
    always_ff @(posedge clk)
    begin
        s1_k      <= k_q;
        s1_even   <= even_i;
        s1_t      <= t_c;
        // stage 2 butterfly, wraps
        wr_addr_q <= s1_k;
        wr_lo_q.re <= s1_even.re + s1_t.re;
        wr_lo_q.im <= s1_even.im + s1_t.im;
        wr_hi_q.re <= s1_even.re - s1_t.re;
        wr_hi_q.im <= s1_even.im - s1_t.im;
    end

    always_comb
    begin
        wr_o.en   = wr_en_q;
        wr_o.addr = wr_addr_q;
        wr_o.lo   = wr_lo_q;
        wr_o.hi   = wr_hi_q;
    end

    assign done_o = done_q;

    // the core may only launch a new pass once the previous one is over
    a_no_restart : assert property (
        @(posedge clk) disable iff (reset) (state == cs_run) |-> !start_i
    );

endmodule

/* hdl/result_buffer.sv */
`include "fft_consts.svh"

module result_buffer
(
    input  logic                       clk,
    input  fft_data_pkg::bfly_write_t  wr_i,
    input  logic                       rd_en_i,
    input  logic [`FFT_ADDR_W-1:0]     rd_addr_i,
    output fft_data_pkg::sample_t      rd_sample_o
);
    import fft_data_pkg::*;

    // low bank holds bins 0..3, high bank bins 4..7
    sample_t  lo_bank [`FFT_LEAF_N];
    sample_t  hi_bank [`FFT_LEAF_N];
    sample_t  rd_q;
    bin_idx_t rd_idx;
    logic     rd_bank;

    assign rd_idx  = rd_addr_i[`FFT_ADDR_W-2:0];
    assign rd_bank = rd_addr_i[`FFT_ADDR_W-1];

    // both halves of a butterfly land in the same cycle
    always_ff @(posedge clk)
    begin
        if (wr_i.en)
        begin
            lo_bank[wr_i.addr] <= wr_i.lo;
            hi_bank[wr_i.addr] <= wr_i.hi;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en_i)
        begin
            rd_q <= rd_bank ? hi_bank[rd_idx] : lo_bank[rd_idx];
        end
    end

    assign rd_sample_o = rd_q;

endmodule

/* hdl/fft8_core.sv */
`include "fft_consts.svh"

module fft8_core
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid_i,
    input  fft_data_pkg::sample_t  in_sample_i,
    input  logic                   out_ready_i,
    output logic                   ready_o,
    output logic                   out_valid_o,
    output fft_data_pkg::sample_t  out_sample_o,
    output logic                   done_o
);
    import fft_data_pkg::*;
    import fft_ctrl_pkg::*;

    core_state_t                  state;
    logic [$clog2(`FFT_N)-1:0]    in_cnt;
    logic [`FFT_ADDR_W-1:0]       rd_addr;
    logic                         accept;
    logic                         even_valid;
    logic                         odd_valid;
    logic                         even_full;
    logic                         odd_full;
    logic                         both_full;
    logic                         both_full_q;
    logic                         comb_start;
    logic                         comb_rd;
    logic                         comb_done;
    logic                         rd_en;
    logic                         out_valid_q;
    sample_t                      even_bin;
    sample_t                      odd_bin;
    bfly_write_t                  wr;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    assign ready_o = (state == st_collect);
    assign accept  = in_valid_i && ready_o;

    // even samples to one leaf, odd to the other
    assign even_valid = accept && !in_cnt[0];
    assign odd_valid  = accept && in_cnt[0];

    fft4_leaf leaf_even
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (even_valid),
        .in_sample_i (in_sample_i),
        .rd_i        (comb_rd),
        .full_o      (even_full),
        .bin_o       (even_bin)
    );

    fft4_leaf leaf_odd
    (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (odd_valid),
        .in_sample_i (in_sample_i),
        .rd_i        (comb_rd),
        .full_o      (odd_full),
        .bin_o       (odd_bin)
    );

    // launch once, on the cycle both leaves become full
    assign both_full  = even_full && odd_full;
    assign comb_start = (state == st_combine) && both_full && !both_full_q;

    twiddle_combine combine
    (
        .clk     (clk),
        .reset   (reset),
        .start_i (comb_start),
        .even_i  (even_bin),
        .odd_i   (odd_bin),
        .rd_o    (comb_rd),
        .wr_o    (wr),
        .done_o  (comb_done)
    );

    result_buffer buffer
    (
        .clk         (clk),
        .wr_i        (wr),
        .rd_en_i     (rd_en),
        .rd_addr_i   (rd_addr),
        .rd_sample_o (out_sample_o)
    );

    ////////////////////////////////////////////////////////////
    // frame FSM and unload sequencing
    ////////////////////////////////////////////////////////////

    assign rd_en = (state == st_unload) && out_ready_i;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= st_collect;
            in_cnt      <= '0;
            rd_addr     <= '0;
            both_full_q <= 1'b0;
            out_valid_q <= 1'b0;
        end
        else
        begin
            both_full_q <= both_full;
            out_valid_q <= rd_en;
            if (accept)
            begin
                in_cnt <= in_cnt + 1'b1;
            end
            if (rd_en)
            begin
                rd_addr <= rd_addr + 1'b1;
            end
            case (state)
                st_collect:
                begin
                    if (accept && (in_cnt == $clog2(`FFT_N)'(`FFT_N - 1)))
                    begin
                        state <= st_combine;
                    end
                end
                st_combine:
                begin
                    if (comb_done)
                    begin
                        state <= st_unload;
                    end
                end
                default:
                begin
                    // 8th bin read issued
                    if (rd_en && (rd_addr == `FFT_ADDR_W'(`FFT_N - 1)))
                    begin
                        state <= st_collect;
                    end
                end
            endcase
        end
    end

    assign out_valid_o = out_valid_q;
    assign done_o      = (state == st_unload);

    // only the last word may trail into collect, once the address has wrapped
    a_valid_in_unload : assert property (
        @(posedge clk) disable iff (reset)
            out_valid_o |-> (state == st_unload) || ((state == st_collect) && (rd_addr == '0))
    );

endmodule

/* bench/fft8_tb.sv */
`include "fft_consts.svh"

module fft8_tb;
    import fft_data_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;
    localparam int CLK_PERIOD  = 100;
    localparam int C45         = 11585;

    logic    clk;
    logic    reset;
    logic    in_valid;
    sample_t in_sample;
    logic    out_ready;
    logic    ready;
    logic    out_valid;
    sample_t out_sample;
    logic    done;
    integer  seed;

    // current frame and its expected bins
    int in_re  [`FFT_N];
    int in_im  [`FFT_N];
    int exp_re [`FFT_N];
    int exp_im [`FFT_N];

    fft8_core dut0
    (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid),
        .in_sample_i  (in_sample),
        .out_ready_i  (out_ready),
        .ready_o      (ready),
        .out_valid_o  (out_valid),
        .out_sample_o (out_sample),
        .done_o       (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic int wrap16(int v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    // Q1.14 product back to sample scale, round half up
    function automatic int round_q14(int v);
        return wrap16((v + 8192) >>> 14);
    endfunction

    task automatic compute_expected();
        int e_re [4];
        int e_im [4];
        int o_re [4];
        int o_im [4];
        int t_re;
        int t_im;
        for (int l = 0; l < 2; l++)
        begin
            int a_re, a_im, b_re, b_im, c_re, c_im, d_re, d_im;
            int r_re [4];
            int r_im [4];
            a_re = in_re[l];
            a_im = in_im[l];
            b_re = in_re[l + 2];
            b_im = in_im[l + 2];
            c_re = in_re[l + 4];
            c_im = in_im[l + 4];
            d_re = in_re[l + 6];
            d_im = in_im[l + 6];
            // 4-point DFT written out with W4 = -j
            r_re[0] = a_re + b_re + c_re + d_re;
            r_im[0] = a_im + b_im + c_im + d_im;
            r_re[1] = a_re + b_im - c_re - d_im;
            r_im[1] = a_im - b_re - c_im + d_re;
            r_re[2] = a_re - b_re + c_re - d_re;
            r_im[2] = a_im - b_im + c_im - d_im;
            r_re[3] = a_re - b_im - c_re + d_im;
            r_im[3] = a_im + b_re - c_im - d_re;
            for (int k = 0; k < 4; k++)
            begin
                if (l == 0)
                begin
                    e_re[k] = wrap16(r_re[k]);
                    e_im[k] = wrap16(r_im[k]);
                end
                else
                begin
                    o_re[k] = wrap16(r_re[k]);
                    o_im[k] = wrap16(r_im[k]);
                end
            end
        end
        for (int k = 0; k < 4; k++)
        begin
            case (k)
                0:
                begin
                    t_re = o_re[k];
                    t_im = o_im[k];
                end
                1:
                begin
                    t_re = round_q14(C45 * o_re[k] + C45 * o_im[k]);
                    t_im = round_q14(C45 * o_im[k] - C45 * o_re[k]);
                end
                2:
                begin
                    t_re = o_im[k];
                    t_im = wrap16(-o_re[k]);
                end
                default:
                begin
                    t_re = round_q14(C45 * o_im[k] - C45 * o_re[k]);
                    t_im = round_q14(-C45 * o_re[k] - C45 * o_im[k]);
                end
            endcase
            exp_re[k]     = wrap16(e_re[k] + t_re);
            exp_im[k]     = wrap16(e_im[k] + t_im);
            exp_re[k + 4] = wrap16(e_re[k] - t_re);
            exp_im[k + 4] = wrap16(e_im[k] - t_im);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < `FFT_N; i++)
        begin
            in_re[i] = $random(seed) % 2001;
            in_im[i] = $random(seed) % 2001;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // frame transfer
    ////////////////////////////////////////////////////////////

    task automatic send_frame();
        for (int i = 0; i < `FFT_N; i++)
        begin
            @(posedge clk);
            in_valid     <= 1'b1;
            in_sample.re <= in_re[i][15:0];
            in_sample.im <= in_im[i][15:0];
            @(negedge clk);
            while (!ready)
                @(negedge clk);
        end
        @(posedge clk);
        in_valid  <= 1'b0;
        in_sample <= '0;
        @(negedge clk);
        check("ready_o", ready, 0);
    endtask

    // bp toggles out_ready, extra sends strobes that must be ignored
    task automatic collect_frame(input bit bp, input bit extra);
        int          n;
        logic [31:0] r;
        logic        seen_ready;
        n = 0;
        while (n < `FFT_N)
        begin
            @(posedge clk);
            // level the DUT sampled on this edge
            seen_ready = out_ready;
            r = $random(seed);
            out_ready <= bp ? r[0] : 1'b1;
            // stop strobing well before ready_o can rise again
            if (extra && n < 6)
            begin
                in_valid     <= r[1];
                in_sample.re <= r[31:16];
                in_sample.im <= r[15:0];
            end
            else
            begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            if (out_valid)
            begin
                // a word only follows a cycle with out_ready_i high
                check("out_valid_o", out_valid, seen_ready);
                check($sformatf("out_sample_o.re bin %0d", n), out_sample.re, exp_re[n]);
                check($sformatf("out_sample_o.im bin %0d", n), out_sample.im, exp_im[n]);
                check("done_o", done, n < `FFT_N - 1);
                n++;
            end
            check("ready_o", ready, n == `FFT_N);
        end
    endtask

    task automatic run_frame(input bit bp, input bit extra);
        send_frame();
        collect_frame(bp, extra);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        @(negedge clk);
        check("ready_o", ready, 1);
        check("done_o", done, 0);
        check("out_valid_o", out_valid, 0);
    endtask

    task automatic test_impulse();
        for (int i = 0; i < `FFT_N; i++)
        begin
            in_re[i]  = (i == 0) ? 1000 : 0;
            in_im[i]  = (i == 0) ? -500 : 0;
            exp_re[i] = 1000;
            exp_im[i] = -500;
        end
        run_frame(1'b0, 1'b0);
    endtask

    task automatic test_constant();
        for (int i = 0; i < `FFT_N; i++)
        begin
            in_re[i]  = 300;
            in_im[i]  = 200;
            exp_re[i] = (i == 0) ? 2400 : 0;
            exp_im[i] = (i == 0) ? 1600 : 0;
        end
        run_frame(1'b0, 1'b0);
    endtask

    task automatic test_random_frames();
        for (int f = 0; f < 2; f++)
        begin
            fill_random();
            compute_expected();
            run_frame(1'b0, 1'b0);
        end
    endtask

    task automatic test_backpressure();
        fill_random();
        compute_expected();
        run_frame(1'b1, 1'b1);
        // next frame must see none of the ignored strobes
        fill_random();
        compute_expected();
        run_frame(1'b1, 1'b0);
    endtask

    initial
    begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the DUT did not finish the tests in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_sample = '0;
        out_ready = 1'b1;
        seed      = 32'h18a1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        test_impulse();
        test_constant();
        test_random_frames();
        test_backpressure();
        $display("TEST OK");
        $finish;
    end

endmodule

/* fft8.f */
+incdir+hdl
hdl/fft_data_pkg.sv
hdl/fft_ctrl_pkg.sv
hdl/fft4_leaf.sv
hdl/twiddle_combine.sv
hdl/result_buffer.sv
hdl/fft8_core.sv
bench/fft8_tb.sv

/* Makefile */
TOP = fft8_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal -f fft8.f --top-module fft8_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f fft8.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir
